/* inorder_core.f */
+incdir+source
+incdir+sim
source/core_pkg.sv
source/fetch_unit.sv
source/decode_dispatch.sv
source/alu_pipe.sv
source/reg_file.sv
source/inorder_core.sv
sim/tb_inorder_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the core testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"
LOG=sim.log

verilator --binary --timing --assert -j 0 \
	--top-module tb_inorder_core -f inorder_core.f -o tb_inorder_core

./obj_dir/tb_inorder_core 2>&1 | tee "$LOG"

if grep -q "TEST FAILED" "$LOG"; then
	echo "simulation reported a failure, see $LOG"
	exit 1
fi
echo "simulation finished without failures"

/* sim/tb_program.svh */
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// image starts one word below the entry point
localparam logic [31:0] PROG_BASE = 32'h0000_0100;
localparam logic [31:0] PROG_ENTRY = 32'h0000_0104;
localparam int PROG_LEN = 26;

localparam logic [31:0] PROG [PROG_LEN] = '{
	32'h7100_0BAD,  // 100 addi r1, r0, 0xbad    below entry, never runs
	32'h8100_1234,  // 104 lui  r1, 0x1234
	32'h7200_0005,  // 108 addi r2, r0, 5
	32'h7300_FFFD,  // 10c addi r3, r0, -3
	32'h7110_5678,  // 110 addi r1, r1, 0x5678
	32'h6422_0000,  // 114 shl  r4, r2, r2
	32'h15F3_0000,  // 118 add  r5, r15, r3
	32'h2652_0000,  // 11c sub  r6, r5, r2
	32'h5716_0000,  // 120 xor  r7, r1, r6
	32'h3871_0000,  // 124 and  r8, r7, r1
	32'h4982_0000,  // 128 or   r9, r8, r2
	32'h9023_000A,  // 12c beq  r2, r3, +10      not taken
	32'hA020_0003,  // 130 bne  r2, r0, +3       taken to 13c
	32'h7A00_0DEA,  // 134 addi r10, r0, 0xdea   skipped
	32'h7B00_0DEB,  // 138 addi r11, r0, 0xdeb   skipped
	32'h7AA0_0001,  // 13c addi r10, r10, 1
	32'h7C00_0003,  // 140 addi r12, r0, 3
	32'h7CC0_FFFF,  // 144 addi r12, r12, -1     loop head
	32'h1DDC_0000,  // 148 add  r13, r13, r12
	32'hA0C0_FFFE,  // 14c bne  r12, r0, -2
	32'h9000_0002,  // 150 beq  r0, r0, +2       taken to 158
	32'h7E00_0BAD,  // 154 addi r14, r0, 0xbad   skipped
	32'h1012_0000,  // 158 add  r0, r1, r2       r0 write is dropped
	32'hF123_4567,  // 15c unused code, acts as nop
	32'h1E9D_0000,  // 160 add  r14, r9, r13
	32'h9000_0000   // 164 beq  r0, r0, 0        self loop
};

`endif

/* sim/tb_inorder_core.sv */
`timescale 1ns/1ps
`default_nettype none
`include "core_cfg.svh"

module tb_inorder_core;
	`include "tb_program.svh"

	localparam int RUN_LIMIT = 4000;    // cycles allowed for the whole program
	localparam int QUIET_CYCLES = 50;

	logic clk = 1'b0;
	logic reset = 1'b1;
	core_pkg::addr_t entry = PROG_ENTRY;
	logic rd_req;
	core_pkg::addr_t rd_addr;
	logic rd_resp = 1'b0;
	core_pkg::line_t rd_data = '0;
	core_pkg::wb_t commit_0;
	core_pkg::wb_t commit_1;

	core_pkg::wb_t exp_q[$];
	int value_errors = 0;
	int other_errors = 0;
	int commits = 0;
	logic [15:0] lfsr = 16'd4957;
	logic pending = 1'b0;
	core_pkg::addr_t held_addr = '0;
	int delay = 0;
	int cycles;

	inorder_core i_dut (.clk, .reset, .entry, .rd_req, .rd_addr, .rd_resp, .rd_data,
		.commit_0, .commit_1);

	initial begin
		forever #50 clk = ~clk;
	end

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// one lfsr step per bit
	function automatic int take_bits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = (v << 1) | int'(lfsr[0]);
		end
		return v;
	endfunction

	function automatic logic [31:0] mem_word(input logic [31:0] a);
		logic [31:0] off;
		off = a - PROG_BASE;
		if (a >= PROG_BASE && off < 32'(PROG_LEN * 4))
			return PROG[int'(off >> 2)];
		return 32'hF000_0000 | ((a ^ (a >> 16)) & 32'h0FFF_FFFF); // fill decodes as nop
	endfunction

	function automatic core_pkg::line_t read_line(input core_pkg::addr_t a);
		core_pkg::line_t l;
		for (int w = 0; w < `CORE_LINE_WORDS; w++)
			l[w*32 +: 32] = mem_word({a[31:4], 4'h0} + 32'(w * 4));
		return l;
	endfunction

	// plain ISA model that walks the program up to the self loop
	function automatic void build_expected();
		core_pkg::word_t r [`CORE_NREGS];
		logic [31:0] pc;
		logic [31:0] w;
		logic [31:0] target;
		core_pkg::word_t a;
		core_pkg::word_t b;
		core_pkg::word_t imm;
		core_pkg::word_t res;
		logic writes;
		logic taken;
		for (int i = 0; i < `CORE_NREGS; i++)
			r[i] = '0;
		r[`CORE_NREGS-1] = `CORE_SP_RESET;
		pc = PROG_ENTRY;
		for (int step = 0; step < 1000; step++) begin
			w = mem_word(pc);
			a = r[w[23:20]];
			b = r[w[19:16]];
			imm = {{16{w[15]}}, w[15:0]};
			res = '0;
			writes = 1'b1;
			taken = 1'b0;
			case (w[31:28])
				4'd1: res = a + b;
				4'd2: res = a - b;
				4'd3: res = a & b;
				4'd4: res = a | b;
				4'd5: res = a ^ b;
				4'd6: res = a << b[4:0];
				4'd7: res = a + imm;
				4'd8: res = {w[15:0], 16'h0000};
				4'd9: begin
					writes = 1'b0;
					taken = (a == b);
				end
				4'd10: begin
					writes = 1'b0;
					taken = (a != b);
				end
				default: writes = 1'b0;
			endcase
			if (writes && w[27:24] != 4'd0) begin
				r[w[27:24]] = res;
				exp_q.push_back('{valid: 1'b1, dst: w[27:24], value: res});
			end
			target = taken ? pc + (imm << 2) : pc + 32'd4;
			if (target == pc)
				break;
			pc = target;
		end
	endfunction

	task automatic check_commit(input core_pkg::wb_t c, input string name);
		core_pkg::wb_t e;
		if (c.valid) begin
			assert (exp_q.size() != 0) else begin
				other_errors++;
				$display("%s wrote r%0d after the expected stream had ended", name, c.dst);
			end
			if (exp_q.size() != 0) begin
				e = exp_q.pop_front();
				commits++;
				assert (c.dst == e.dst) else begin
					value_errors++;
					$display("[FAIL] %s.dst expected %h got %h", name, e.dst, c.dst);
				end
				assert (c.value == e.value) else begin
					value_errors++;
					$display("[FAIL] %s.value expected %h got %h", name, e.value, c.value);
				end
			end
		end
	endtask

	// commit_0 is the older one, so it is matched first
	always @(negedge clk) begin
		check_commit(commit_0, "commit_0");
		check_commit(commit_1, "commit_1");
	end

	// memory with 1 to 8 cycles of latency per line
	always @(negedge clk) begin
		rd_resp = 1'b0;
		assert (!(pending && !rd_req)) else begin
			other_errors++;
			$display("rd_req dropped before its response");
			pending = 1'b0;
		end
		if (rd_req) begin
			if (!pending) begin
				pending = 1'b1;
				held_addr = rd_addr;
				delay = take_bits(3) + 1;
			end
			assert (rd_addr == held_addr) else begin
				value_errors++;
				$display("[FAIL] rd_addr expected %h got %h", held_addr, rd_addr);
			end
			delay = delay - 1;
			if (delay == 0) begin
				rd_resp = 1'b1;
				rd_data = read_line(rd_addr);
				pending = 1'b0;
			end
		end
	end

	task automatic check_idle_outputs();
		assert (!rd_req) else begin
			value_errors++;
			$display("[FAIL] rd_req expected 0 got %h", rd_req);
		end
		assert (!commit_0.valid) else begin
			value_errors++;
			$display("[FAIL] commit_0.valid expected 0 got %h", commit_0.valid);
		end
		assert (!commit_1.valid) else begin
			value_errors++;
			$display("[FAIL] commit_1.valid expected 0 got %h", commit_1.valid);
		end
	endtask

	initial begin
		build_expected();
		$display("expecting %0d commits", exp_q.size());
		repeat (16) begin
			@(negedge clk);
			check_idle_outputs();
		end
		reset = 1'b0;
		check_idle_outputs();   // outputs still come from the reset state
		@(negedge clk);
		assert (rd_req) else begin
			other_errors++;
			$display("first line request missing on the cycle after reset");
		end
		assert (rd_addr == {PROG_ENTRY[31:4], 4'h0}) else begin
			value_errors++;
			$display("[FAIL] rd_addr expected %h got %h", {PROG_ENTRY[31:4], 4'h0}, rd_addr);
		end
		cycles = 0;
		while (exp_q.size() != 0 && cycles < RUN_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		if (exp_q.size() != 0) begin
			other_errors++;
			$display("timeout with %0d commits still missing", exp_q.size());
		end else begin
			repeat (QUIET_CYCLES) @(negedge clk);   // self loop spins with nothing left to commit
			@(posedge clk);
		end
		$display("commits checked %0d, value errors %0d, other errors %0d",
			commits, value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* source/inorder_core.sv */
`timescale 1ns/1ps
`default_nettype none

module inorder_core (
	input  logic            clk,
	input  logic            reset,
	input  core_pkg::addr_t entry,
	output logic            rd_req,
	output core_pkg::addr_t rd_addr,
	input  logic            rd_resp,
	input  core_pkg::line_t rd_data,
	output core_pkg::wb_t   commit_0,
	output core_pkg::wb_t   commit_1
);
	core_pkg::insn_t insn0;
	core_pkg::insn_t insn1;
	core_pkg::addr_t pc0;
	core_pkg::addr_t pc1;
	logic [1:0] avail;
	logic [1:0] consume;
	logic fetch_busy;
	logic redirect;
	core_pkg::addr_t redirect_pc;
	logic issue_0;
	logic issue_1;
	core_pkg::micro_op_t mop_0;
	core_pkg::micro_op_t mop_1;
	core_pkg::wb_t wb_0;
	core_pkg::wb_t wb_1;
	core_pkg::reg_array_t regs;

	fetch_unit i_fetch (
		.clk, .reset, .entry, .redirect, .redirect_pc, .consume,
		.rd_req, .rd_addr, .rd_resp, .rd_data,
		.insn0, .insn1, .pc0, .pc1, .avail, .fetch_busy
	);

	decode_dispatch i_dispatch (
		.clk, .reset, .insn0, .insn1, .pc0, .pc1, .avail, .fetch_busy, .rd_resp,
		.regs, .wb_0, .wb_1, .consume, .redirect, .redirect_pc,
		.issue_0, .issue_1, .mop_0, .mop_1
	);

	alu_pipe i_alu_0 (.clk, .reset, .issue(issue_0), .mop(mop_0), .wb(wb_0));

	alu_pipe i_alu_1 (.clk, .reset, .issue(issue_1), .mop(mop_1), .wb(wb_1));

	reg_file i_regs (.clk, .reset, .wb_0, .wb_1, .regs, .commit_0, .commit_1);

endmodule

`default_nettype wire

/* source/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none
`include "core_cfg.svh"

module reg_file (
	input  logic                 clk,
	input  logic                 reset,
	input  core_pkg::wb_t        wb_0,
	input  core_pkg::wb_t        wb_1,
	output core_pkg::reg_array_t regs,
	output core_pkg::wb_t        commit_0,
	output core_pkg::wb_t        commit_1
);
	localparam int NPORT = `CORE_ISSUE;

	core_pkg::wb_t wb_in [NPORT];
	core_pkg::wb_t commit_r [NPORT];
	core_pkg::reg_array_t regs_r;

	assign wb_in[0] = wb_0;
	assign wb_in[1] = wb_1;

	always_ff @(posedge clk) begin
		if (reset) begin
			regs_r <= '0;
			regs_r[`CORE_NREGS-1] <= `CORE_SP_RESET;    // stack pointer
		end else begin
			for (int p = 0; p < NPORT; p++) begin
				if (wb_in[p].valid && wb_in[p].dst != '0)
					regs_r[wb_in[p].dst] <= wb_in[p].value;
			end
		end
	end

	// commit mirrors the register write of the same edge
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int p = 0; p < NPORT; p++)
				commit_r[p] <= '0;
		end else begin
			for (int p = 0; p < NPORT; p++) begin
				commit_r[p] <= '{valid: wb_in[p].valid && (wb_in[p].dst != '0),
					dst: wb_in[p].dst, value: wb_in[p].value};
			end
		end
	end

	assign regs = regs_r;
	assign commit_0 = commit_r[0];
	assign commit_1 = commit_r[1];

	a_no_dup_write: assert property (@(posedge clk) disable iff (reset)
		wb_0.valid && wb_1.valid && wb_0.dst != '0 |-> wb_0.dst != wb_1.dst);

endmodule

`default_nettype wire

/* source/alu_pipe.sv */
`timescale 1ns/1ps
`default_nettype none
`include "core_cfg.svh"

module alu_pipe (
	input  logic                clk,
	input  logic                reset,
	input  logic                issue,
	input  core_pkg::micro_op_t mop,
	output core_pkg::wb_t       wb
);
	localparam int SHAMT_W = $clog2(`CORE_XLEN);

	core_pkg::word_t result;

	logic s1_valid;
	core_pkg::reg_id_t s1_dst;
	core_pkg::word_t s1_value;

	logic wb_valid;
	core_pkg::reg_id_t wb_dst;
	core_pkg::word_t wb_value;

	always_comb begin
		case (mop.opcode)
			core_pkg::OP_ADD:  result = mop.src0_val + mop.src1_val;
			core_pkg::OP_SUB:  result = mop.src0_val - mop.src1_val;
			core_pkg::OP_AND:  result = mop.src0_val & mop.src1_val;
			core_pkg::OP_OR:   result = mop.src0_val | mop.src1_val;
			core_pkg::OP_XOR:  result = mop.src0_val ^ mop.src1_val;
			core_pkg::OP_SHL:  result = mop.src0_val << mop.src1_val[SHAMT_W-1:0];
			core_pkg::OP_ADDI: result = mop.src0_val + mop.imm;
			core_pkg::OP_LUI:  result = mop.imm << 16;
			default:           result = '0;    // branches never get here
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			s1_valid <= 1'b0;
			wb_valid <= 1'b0;
		end else begin
			s1_valid <= issue;
			wb_valid <= s1_valid;
		end
	end

	always_ff @(posedge clk) begin
		s1_dst <= mop.dst;
		s1_value <= result;     // stage one
		wb_dst <= s1_dst;
		wb_value <= s1_value;   // stage two
	end

	assign wb = '{valid: wb_valid, dst: wb_dst, value: wb_value};

	a_two_cycle: assert property (@(posedge clk) disable iff (reset)
		wb.valid == $past(issue, 2));

endmodule

`default_nettype wire

/* source/decode_dispatch.sv */
`timescale 1ns/1ps
`default_nettype none
`include "core_cfg.svh"

module decode_dispatch (
	input  logic                  clk,
	input  logic                  reset,
	input  core_pkg::insn_t       insn0,
	input  core_pkg::insn_t       insn1,
	input  core_pkg::addr_t       pc0,
	input  core_pkg::addr_t       pc1,
	input  logic [1:0]            avail,
	input  logic                  fetch_busy,
	input  logic                  rd_resp,
	input  core_pkg::reg_array_t  regs,
	input  core_pkg::wb_t         wb_0,
	input  core_pkg::wb_t         wb_1,
	output logic [1:0]            consume,
	output logic                  redirect,
	output core_pkg::addr_t       redirect_pc,
	output logic                  issue_0,
	output logic                  issue_1,
	output core_pkg::micro_op_t   mop_0,
	output core_pkg::micro_op_t   mop_1
);
	localparam int NSLOT = `CORE_ISSUE;

	logic [`CORE_NREGS-1:0] sb_r;    // write in flight per register
	logic [`CORE_NREGS-1:0] sb_set;  // marked by this cycle's issue
	logic [`CORE_NREGS-1:0] sb_clr;  // cleared by this cycle's write-back

	core_pkg::insn_t slot_insn [NSLOT];
	core_pkg::addr_t slot_pc [NSLOT];
	core_pkg::micro_op_t slot_mop [NSLOT];
	logic [NSLOT-1:0] slot_issue;

	function automatic core_pkg::opcode_t decode_op(input logic [3:0] code);
		if (code > 4'(core_pkg::OP_BNE))
			decode_op = core_pkg::OP_NOP;
		else
			decode_op = core_pkg::opcode_t'(code);
	endfunction

	function automatic core_pkg::word_t read_reg(input core_pkg::reg_array_t rf,
			input core_pkg::reg_id_t id);
		read_reg = (id == '0) ? '0 : rf[id];
	endfunction

	assign slot_insn[0] = insn0;
	assign slot_insn[1] = insn1;
	assign slot_pc[0] = pc0;
	assign slot_pc[1] = pc1;

	// slots are walked oldest first, a stall stops everything behind it
	always_comb begin
		logic stop;
		logic [1:0] cnt;
		logic is_alu;
		logic use_s0;
		logic use_s1;
		logic use_dst;
		logic hazard;
		logic taken;
		core_pkg::opcode_t op;
		core_pkg::reg_id_t dst;
		core_pkg::reg_id_t s0;
		core_pkg::reg_id_t s1;
		core_pkg::word_t v0;
		core_pkg::word_t v1;
		core_pkg::word_t imm;

		stop = 1'b0;
		cnt = '0;
		sb_set = '0;
		slot_issue = '0;
		redirect = 1'b0;
		redirect_pc = '0;
		for (int i = 0; i < NSLOT; i++) begin
			op = decode_op(slot_insn[i][31:28]);
			dst = slot_insn[i][27:24];
			s0 = slot_insn[i][23:20];
			s1 = slot_insn[i][19:16];
			imm = core_pkg::word_t'(signed'(slot_insn[i][15:0]));
			v0 = read_reg(regs, s0);
			v1 = read_reg(regs, s1);

			is_alu = !(op inside {core_pkg::OP_NOP, core_pkg::OP_BEQ, core_pkg::OP_BNE});
			use_s0 = !(op inside {core_pkg::OP_NOP, core_pkg::OP_LUI});
			use_s1 = !(op inside {core_pkg::OP_NOP, core_pkg::OP_LUI, core_pkg::OP_ADDI});
			use_dst = is_alu && (dst != '0);
			hazard = (use_s0 && (sb_r[s0] || sb_set[s0])) ||
				(use_s1 && (sb_r[s1] || sb_set[s1])) ||
				(use_dst && (sb_r[dst] || sb_set[dst]));
			taken = ((op == core_pkg::OP_BEQ) && (v0 == v1)) ||
				((op == core_pkg::OP_BNE) && (v0 != v1));

			slot_mop[i] = '{opcode: op, dst: dst, src0_val: v0, src1_val: v1, imm: imm};

			if (stop || i >= int'(avail) || hazard) begin
				stop = 1'b1;
			end else if (taken) begin
				stop = 1'b1;    // taken branch closes the group
				// a line read still in flight would land on the wrong path
				if (!fetch_busy || rd_resp) begin
					redirect = 1'b1;
					redirect_pc = slot_pc[i] + core_pkg::addr_t'(imm << 2);
					cnt = cnt + 2'd1;
				end
			end else begin
				cnt = cnt + 2'd1;   // NOP and not-taken branch just retire here
				if (is_alu) begin
					slot_issue[i] = 1'b1;
					if (use_dst)
						sb_set[dst] = 1'b1;
				end
			end
		end
		consume = cnt;
	end

	always_comb begin
		sb_clr = '0;
		if (wb_0.valid)
			sb_clr[wb_0.dst] = 1'b1;
		if (wb_1.valid)
			sb_clr[wb_1.dst] = 1'b1;
	end

	// bits drop at the write edge, so a reader sees the new register next cycle
	always_ff @(posedge clk) begin
		if (reset)
			sb_r <= '0;
		else
			sb_r <= (sb_r & ~sb_clr) | sb_set;
	end

	assign issue_0 = slot_issue[0];
	assign issue_1 = slot_issue[1];
	assign mop_0 = slot_mop[0];
	assign mop_1 = slot_mop[1];

	a_wb0_pending: assert property (@(posedge clk) disable iff (reset)
		wb_0.valid && wb_0.dst != '0 |-> sb_r[wb_0.dst] && !sb_set[wb_0.dst]);

	a_wb1_pending: assert property (@(posedge clk) disable iff (reset)
		wb_1.valid && wb_1.dst != '0 |-> sb_r[wb_1.dst] && !sb_set[wb_1.dst]);

	a_r0_unmarked: assert property (@(posedge clk) disable iff (reset) !sb_r[0]);

endmodule

`default_nettype wire

/* source/fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none
`include "core_cfg.svh"

module fetch_unit (
	input  logic            clk,
	input  logic            reset,
	input  core_pkg::addr_t entry,
	input  logic            redirect,
	input  core_pkg::addr_t redirect_pc,
	input  logic [1:0]      consume,
	output logic            rd_req,
	output core_pkg::addr_t rd_addr,
	input  logic            rd_resp,
	input  core_pkg::line_t rd_data,
	output core_pkg::insn_t insn0,
	output core_pkg::insn_t insn1,
	output core_pkg::addr_t pc0,
	output core_pkg::addr_t pc1,
	output logic [1:0]      avail,
	output logic            fetch_busy
);
	localparam int DEPTH = `CORE_FQ_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);
	localparam int WORD_W = $clog2(`CORE_LINE_WORDS);
	localparam int LINE_BYTES = `CORE_LINE_WORDS * 4;

	typedef logic [PTR_W:0] cnt_t;

	core_pkg::insn_t q_insn [DEPTH];
	core_pkg::addr_t q_pc [DEPTH];
	logic [PTR_W-1:0] head;
	logic [PTR_W-1:0] head_nx;
	logic [PTR_W-1:0] tail;
	cnt_t count;                    // 0 to DEPTH
	cnt_t count_next;
	core_pkg::addr_t fetch_addr;    // mid-line after entry or a redirect
	core_pkg::addr_t line_base;
	logic [WORD_W-1:0] first_word;
	logic [WORD_W:0] n_in;          // words of the line that go into the queue
	logic req_r;

	assign line_base = {fetch_addr[31:WORD_W+2], {(WORD_W+2){1'b0}}};
	assign first_word = fetch_addr[WORD_W+1:2];
	assign n_in = (WORD_W+1)'(`CORE_LINE_WORDS) - (WORD_W+1)'(first_word);
	assign tail = head + count[PTR_W-1:0];
	assign head_nx = head + PTR_W'(1);
	assign count_next = count - cnt_t'(consume) + (rd_resp ? cnt_t'(n_in) : cnt_t'(0));

	always_ff @(posedge clk) begin
		if (reset) begin
			req_r <= 1'b0;
			fetch_addr <= entry;
			head <= '0;
			count <= '0;
		end else if (redirect) begin
			req_r <= 1'b1;              // queue is empty now
			fetch_addr <= redirect_pc;
			head <= '0;
			count <= '0;
		end else begin
			head <= head + PTR_W'(consume);
			count <= count_next;
			if (rd_resp)
				fetch_addr <= line_base + LINE_BYTES;
			// hold the level until the response, then re-check room
			if (rd_resp || !req_r)
				req_r <= (cnt_t'(DEPTH) - count_next) >= cnt_t'(`CORE_LINE_WORDS);
		end
	end

	// a response in the redirect cycle belongs to the old path
	always_ff @(posedge clk) begin
		if (rd_resp && !redirect) begin
			for (int i = 0; i < `CORE_LINE_WORDS; i++) begin
				if (i < int'(n_in)) begin
					q_insn[tail + PTR_W'(i)] <= rd_data[(int'(first_word) + i) * 32 +: 32];
					q_pc[tail + PTR_W'(i)] <= line_base + core_pkg::addr_t'((int'(first_word) + i) * 4);
				end
			end
		end
	end

	assign rd_req = req_r;
	assign rd_addr = line_base;
	assign fetch_busy = req_r;

	assign insn0 = q_insn[head];
	assign insn1 = q_insn[head_nx];
	assign pc0 = q_pc[head];
	assign pc1 = q_pc[head_nx];
	assign avail = (count >= cnt_t'(2)) ? 2'd2 : count[1:0];

	a_addr_stable: assert property (@(posedge clk) disable iff (reset)
		rd_req && !rd_resp |=> rd_req && $stable(rd_addr));

	a_consume_le_avail: assert property (@(posedge clk) disable iff (reset)
		consume <= avail);

endmodule

`default_nettype wire

/* source/core_pkg.sv */
`default_nettype none
`include "core_cfg.svh"

package core_pkg;

	typedef logic [`CORE_XLEN-1:0] word_t;
	typedef logic [31:0] addr_t;
	typedef logic [$clog2(`CORE_NREGS)-1:0] reg_id_t;
	typedef logic [31:0] insn_t;

	// lowest address sits in the low word
	typedef logic [`CORE_LINE_WORDS*32-1:0] line_t;

	// encodings live in insn[31:28]; codes above OP_BNE decode as OP_NOP
	typedef enum logic [3:0] {
		OP_NOP  = 4'd0,
		OP_ADD  = 4'd1,
		OP_SUB  = 4'd2,
		OP_AND  = 4'd3,
		OP_OR   = 4'd4,
		OP_XOR  = 4'd5,
		OP_SHL  = 4'd6,
		OP_ADDI = 4'd7,
		OP_LUI  = 4'd8,
		OP_BEQ  = 4'd9,
		OP_BNE  = 4'd10
	} opcode_t;

	// one issued operation with its operands already read
	typedef struct packed {
		opcode_t opcode;
		reg_id_t dst;
		word_t   src0_val;
		word_t   src1_val;
		word_t   imm;      // sign extended
	} micro_op_t;

	typedef struct packed {
		logic    valid;
		reg_id_t dst;
		word_t   value;
	} wb_t;

	typedef word_t [`CORE_NREGS-1:0] reg_array_t;

endpackage

`default_nettype wire

/* source/core_cfg.svh */
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// register value width
`define CORE_XLEN 32

// architectural registers with r0 reading as zero
`define CORE_NREGS 16

// instructions per fetched line (16 bytes)
`define CORE_LINE_WORDS 4

// instruction queue slots (a power of two)
`define CORE_FQ_DEPTH 8

// issue width with one ALU pipe per slot
`define CORE_ISSUE 2

// r15 acts as stack pointer
`define CORE_SP_RESET 32'h2000_0000

`endif
